//--- flist.f
+incdir+include
hdl/lsu_pkg.sv
hdl/lsu_age_check.sv
hdl/lsu_replay_queue.sv
hdl/lsu_pipe.sv
hdl/lsu.sv
hdl/lsu_top.sv
verif/wb_mem_model.sv
verif/tb_lsu_top.sv

//--- run.sh
#!/bin/sh
# Build and run the LSU testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -f flist.f --top-module tb_lsu_top -Mdir obj_dir

./obj_dir/Vtb_lsu_top > sim.log 2>&1
cat sim.log

if grep -q "Some tests failed" sim.log; then
   echo "Simulation reported failures, see sim.log"
   exit 1
fi

echo "Simulation finished without failures"
exit 0

//--- verif/tb_lsu_top.sv
`include "lsu_cfg.svh"

module tb_lsu_top;
   import lsu_pkg::*;

   localparam int N_OPS       = 40;
   localparam int WORDS       = 1 << (`LSU_ADDR_W - 2);
   localparam int CYCLE_LIMIT = N_OPS * 12;

   logic i_clk = 1'b0;
   logic i_reset;
   logic i_ld_valid;
   logic o_ld_ready;
   cmt_id_t i_ld_cmt_id;
   grp_id_t i_ld_grp_id;
   addr_t i_ld_addr;
   op_payload_u i_ld_payload;
   logic i_st_valid;
   logic o_st_ready;
   cmt_id_t i_st_cmt_id;
   grp_id_t i_st_grp_id;
   addr_t i_st_addr;
   size_t i_st_size;
   op_payload_u i_st_payload;

   logic wb_cyc;
   logic wb_stb;
   logic wb_we;
   addr_t wb_adr;
   data_t wb_dat_w;
   data_t wb_dat_r;
   logic [`LSU_DATA_W/8-1:0] wb_sel;
   logic wb_ack;

   logic o_done_valid;
   cmt_id_t o_done_cmt_id;
   grp_id_t o_done_grp_id;
   logic o_done_is_store;
   rd_t o_done_rd;
   data_t o_done_data;

   // Program and expected results
   logic    prog_store    [N_OPS];
   cmt_id_t prog_cmt      [N_OPS];
   grp_id_t prog_grp      [N_OPS];
   addr_t   prog_addr     [N_OPS];
   size_t   prog_size     [N_OPS];
   logic    prog_unsigned [N_OPS];
   rd_t     prog_rd       [N_OPS];
   data_t   prog_data     [N_OPS];
   data_t   exp_data      [N_OPS];
   logic [7:0] shadow_mem [WORDS*4];

   logic [31:0] rng_state = 32'heef7_2abf;
   int done_count = 0;
   int cycle_count = 0;
   int stalls = 0;
   int ld_sent = 0;
   int st_sent = 0;
   int ld_done = 0;
   int st_done = 0;
   int err_id = 0;
   int err_data = 0;
   int err_rd = 0;
   int err_kind = 0;
   int err_ready = 0;
   int err_other = 0;
   string op_name;

   always #20 i_clk = ~i_clk;

   lsu_top i_dut (
      .i_clk (i_clk), .i_reset (i_reset),
      .i_ld_valid (i_ld_valid), .o_ld_ready (o_ld_ready), .i_ld_cmt_id (i_ld_cmt_id),
      .i_ld_grp_id (i_ld_grp_id), .i_ld_addr (i_ld_addr), .i_ld_payload (i_ld_payload),
      .i_st_valid (i_st_valid), .o_st_ready (o_st_ready), .i_st_cmt_id (i_st_cmt_id),
      .i_st_grp_id (i_st_grp_id), .i_st_addr (i_st_addr), .i_st_size (i_st_size),
      .i_st_payload (i_st_payload),
      .o_wb_cyc (wb_cyc), .o_wb_stb (wb_stb), .o_wb_we (wb_we), .o_wb_adr (wb_adr),
      .o_wb_dat (wb_dat_w), .o_wb_sel (wb_sel), .i_wb_dat (wb_dat_r), .i_wb_ack (wb_ack),
      .o_done_valid (o_done_valid), .o_done_cmt_id (o_done_cmt_id),
      .o_done_grp_id (o_done_grp_id), .o_done_is_store (o_done_is_store),
      .o_done_rd (o_done_rd), .o_done_data (o_done_data)
   );

   wb_mem_model u_mem (
      .i_clk (i_clk), .i_reset (i_reset), .i_cyc (wb_cyc), .i_stb (wb_stb), .i_we (wb_we),
      .i_adr (wb_adr), .i_dat (wb_dat_w), .i_sel (wb_sel), .o_dat (wb_dat_r), .o_ack (wb_ack)
   );

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   task automatic draw_bits(input int n, output logic [31:0] val);
      val = '0;
      for (int i = 0; i < n; i++) begin
         val[i] = rng_state[0];
         rng_state = lfsr_next(rng_state);
      end
   endtask

   // ====================
   // Reference model
   // ====================

   // Applies one operation to the byte-wide shadow memory and returns load data
   function automatic data_t ref_op(input int k);
      int    nbytes;
      int    a;
      data_t val;
      nbytes = (prog_size[k] == SZ_BYTE) ? 1 : (prog_size[k] == SZ_HALF) ? 2 : 4;
      val = '0;
      for (int b = 0; b < nbytes; b++) begin
         a = int'(prog_addr[k]) + b;
         if (prog_store[k]) begin
            shadow_mem[a] = prog_data[k][8*b +: 8];
         end else begin
            val[8*b +: 8] = shadow_mem[a];
         end
      end
      // Sign fill above the loaded bytes
      if (!prog_store[k] && !prog_unsigned[k] && val[8*nbytes-1]) begin
         for (int b = nbytes; b < 4; b++) begin
            val[8*b +: 8] = 8'hff;
         end
      end
      return prog_store[k] ? '0 : val;
   endfunction

   task automatic build_program();
      logic [31:0] r;
      logic [31:0] word;
      logic [1:0]  lane;
      for (int w = 0; w < WORDS; w++) begin
         word = {10'(w), 2'b01, ~10'(w), 10'(w)};
         for (int b = 0; b < 4; b++) begin
            shadow_mem[4*w + b] = word[8*b +: 8];
         end
      end
      for (int k = 0; k < N_OPS; k++) begin
         draw_bits(1, r);
         prog_store[k] = r[0];
         draw_bits(2, r);
         prog_size[k] = (r[1:0] == 2'd3) ? SZ_WORD : size_t'(r[1:0]);
         // Eight words at 0x3a0 so loads often hit earlier stores
         draw_bits(5, r);
         lane = (prog_size[k] == SZ_BYTE) ? r[1:0] :
                (prog_size[k] == SZ_HALF) ? {r[1], 1'b0} : 2'b00;
         prog_addr[k] = {7'b0011101, r[4:2], lane};
         draw_bits(1, r);
         prog_unsigned[k] = r[0];
         draw_bits(5, r);
         prog_rd[k] = r[4:0];
         draw_bits(32, r);
         prog_data[k] = r;
         // Two group slots per commit id that wraps past 15
         prog_cmt[k] = cmt_id_t'(k / 2);
         prog_grp[k] = (k % 2 == 0) ? 2'b01 : 2'b10;
         exp_data[k] = ref_op(k);
      end
   endtask

   // Starts 2 units after an edge and returns at the same point after the transfer
   task automatic dispatch_op(input int k);
      if (prog_store[k]) begin
         i_st_valid = 1'b1;
         i_st_cmt_id = prog_cmt[k];
         i_st_grp_id = prog_grp[k];
         i_st_addr = prog_addr[k];
         i_st_size = prog_size[k];
         i_st_payload.st_data = prog_data[k];
      end else begin
         i_ld_valid = 1'b1;
         i_ld_cmt_id = prog_cmt[k];
         i_ld_grp_id = prog_grp[k];
         i_ld_addr = prog_addr[k];
         i_ld_payload = '0;
         i_ld_payload.ld.rd = prog_rd[k];
         i_ld_payload.ld.size = prog_size[k];
         i_ld_payload.ld.is_unsigned = prog_unsigned[k];
      end
      check_ready(k);
      while (!(prog_store[k] ? o_st_ready : o_ld_ready)) begin
         stalls++;
         @(posedge i_clk);
         #2;
         check_ready(k);
      end
      @(posedge i_clk);
      #2;
      i_ld_valid = 1'b0;
      i_st_valid = 1'b0;
      if (prog_store[k]) begin
         st_sent++;
      end else begin
         ld_sent++;
      end
   endtask

   // ====================
   // Checks
   // ====================
   task automatic check_id(input string name, input cmt_id_t exp_cmt, input grp_id_t exp_grp,
                           input cmt_id_t act_cmt, input grp_id_t act_grp);
      if (exp_cmt !== act_cmt || exp_grp !== act_grp) begin
         $display("[ERROR] %s id expected %h/%b actual %h/%b",
                  name, exp_cmt, exp_grp, act_cmt, act_grp);
         err_id++;
      end
   endtask

   task automatic check_data(input string name, input data_t exp, input data_t act);
      if (exp !== act) begin
         $display("[ERROR] %s data expected %h actual %h", name, exp, act);
         err_data++;
      end
   endtask

   task automatic check_rd(input string name, input rd_t exp, input rd_t act);
      if (exp !== act) begin
         $display("[ERROR] %s rd expected %0d actual %0d", name, exp, act);
         err_rd++;
      end
   endtask

   task automatic check_kind(input string name, input logic exp, input logic act);
      if (exp !== act) begin
         $display("[ERROR] %s is_store expected %b actual %b", name, exp, act);
         err_kind++;
      end
   endtask

   // A full queue drops ready, and at most one more op of that kind sits in the pipe
   task automatic check_ready(input int k);
      int   in_flight;
      int   depth;
      logic act;
      logic exp;
      in_flight = prog_store[k] ? st_sent - st_done : ld_sent - ld_done;
      depth = prog_store[k] ? `LSU_STQ_DEPTH : `LSU_LDQ_DEPTH;
      act = prog_store[k] ? o_st_ready : o_ld_ready;
      exp = in_flight < depth;
      if (in_flight != depth && exp !== act) begin
         $display("[ERROR] op %0d ready expected %b actual %b with %0d in flight",
                  k, exp, act, in_flight);
         err_ready++;
      end
   endtask

   // Done pulses must follow program order exactly
   always @(negedge i_clk) begin
      if (!i_reset && o_done_valid) begin
         if (done_count >= N_OPS) begin
            $display("Done pulse seen after all %0d operations had finished", N_OPS);
            err_other++;
         end else begin
            op_name = $sformatf("op %0d", done_count);
            check_id(op_name, prog_cmt[done_count], prog_grp[done_count],
                     o_done_cmt_id, o_done_grp_id);
            check_kind(op_name, prog_store[done_count], o_done_is_store);
            check_rd(op_name, prog_store[done_count] ? '0 : prog_rd[done_count], o_done_rd);
            check_data(op_name, exp_data[done_count], o_done_data);
            if (prog_store[done_count]) begin
               st_done++;
            end else begin
               ld_done++;
            end
         end
         done_count++;
      end
   end

   always @(posedge i_clk) begin
      cycle_count++;
      if (cycle_count > CYCLE_LIMIT) begin
         $display("Timeout after %0d cycles with %0d of %0d operations done",
                  cycle_count, done_count, N_OPS);
         $display("Some tests failed");
         $finish;
      end
   end

   initial begin
      i_reset = 1'b1;
      i_ld_valid = 1'b0;
      i_ld_cmt_id = '0;
      i_ld_grp_id = '0;
      i_ld_addr = '0;
      i_ld_payload = '0;
      i_st_valid = 1'b0;
      i_st_cmt_id = '0;
      i_st_grp_id = '0;
      i_st_addr = '0;
      i_st_size = SZ_BYTE;
      i_st_payload = '0;
      build_program();
      repeat (3) @(posedge i_clk);
      #2;
      // Bus and done port idle, both queues empty
      if (wb_cyc !== 1'b0 || wb_stb !== 1'b0 || o_done_valid !== 1'b0 ||
          o_ld_ready !== 1'b1 || o_st_ready !== 1'b1) begin
         $display("Bus, done port or dispatch ready not idle after reset");
         err_other++;
      end
      i_reset = 1'b0;
      for (int k = 0; k < N_OPS; k++) begin
         dispatch_op(k);
      end
      while (done_count < N_OPS) begin
         @(posedge i_clk);
      end
      // Room for any stray extra done pulse
      repeat (8) @(posedge i_clk);
      if (stalls == 0) begin
         $display("Dispatch never saw back-pressure from a full queue");
         err_other++;
      end
      $display("Error counts: id %0d, data %0d, rd %0d, kind %0d, ready %0d, other %0d",
               err_id, err_data, err_rd, err_kind, err_ready, err_other);
      if (err_id + err_data + err_rd + err_kind + err_ready + err_other == 0) begin
         $display("All tests passed");
      end else begin
         $display("Some tests failed");
      end
      $finish;
   end

endmodule

//--- verif/wb_mem_model.sv
`include "lsu_cfg.svh"

module wb_mem_model (
   input  logic                     i_clk,
   input  logic                     i_reset,
   input  logic                     i_cyc,
   input  logic                     i_stb,
   input  logic                     i_we,
   input  lsu_pkg::addr_t           i_adr,
   input  lsu_pkg::data_t           i_dat,
   input  logic [`LSU_DATA_W/8-1:0] i_sel,
   output lsu_pkg::data_t           o_dat,
   output logic                     o_ack
);
   import lsu_pkg::*;

   localparam int WORDS = 1 << (`LSU_ADDR_W - 2);

   data_t       mem [WORDS];
   logic [31:0] r_lfsr;
   logic [31:0] w_lfsr_mid;
   logic [1:0]  w_delay;
   logic        r_busy;
   logic [1:0]  r_wait;

   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      lfsr_next = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   // Word pattern built from every bit of the word index
   initial begin
      for (int i = 0; i < WORDS; i++) begin
         mem[i] = {10'(i), 2'b01, ~10'(i), 10'(i)};
      end
      o_ack = 1'b0;
      o_dat = '0;
   end

   // Two LFSR bits give the extra wait, 0 to 3 cycles
   assign w_lfsr_mid = lfsr_next(r_lfsr);
   assign w_delay    = {w_lfsr_mid[0], r_lfsr[0]};

   always @(posedge i_clk) begin
      if (i_reset) begin
         o_ack  <= 1'b0;
         o_dat  <= '0;
         r_busy <= 1'b0;
         r_wait <= '0;
         r_lfsr <= 32'heef7_2abf;
      end else begin
         o_ack <= 1'b0;
         if (i_cyc && i_stb && !o_ack) begin
            if (!r_busy) begin
               r_busy <= 1'b1;
               r_wait <= w_delay;
               r_lfsr <= lfsr_next(w_lfsr_mid);
            end else if (r_wait != '0) begin
               r_wait <= r_wait - 1'b1;
            end else begin
               for (int b = 0; b < `LSU_DATA_W / 8; b++) begin
                  if (i_we && i_sel[b]) begin
                     mem[i_adr[`LSU_ADDR_W-1:2]][8*b +: 8] <= i_dat[8*b +: 8];
                  end
               end
               o_dat  <= mem[i_adr[`LSU_ADDR_W-1:2]];
               o_ack  <= 1'b1;
               r_busy <= 1'b0;
            end
         end
      end
   end

endmodule

//--- hdl/lsu_top.sv
`include "lsu_cfg.svh"

module lsu_top (
   input  logic                     i_clk,
   input  logic                     i_reset,

   // Load dispatch
   input  logic                     i_ld_valid,
   output logic                     o_ld_ready,
   input  lsu_pkg::cmt_id_t         i_ld_cmt_id,
   input  lsu_pkg::grp_id_t         i_ld_grp_id,
   input  lsu_pkg::addr_t           i_ld_addr,
   input  lsu_pkg::op_payload_u     i_ld_payload,

   // Store dispatch
   input  logic                     i_st_valid,
   output logic                     o_st_ready,
   input  lsu_pkg::cmt_id_t         i_st_cmt_id,
   input  lsu_pkg::grp_id_t         i_st_grp_id,
   input  lsu_pkg::addr_t           i_st_addr,
   input  lsu_pkg::size_t           i_st_size,
   input  lsu_pkg::op_payload_u     i_st_payload,

   output logic                     o_wb_cyc,
   output logic                     o_wb_stb,
   output logic                     o_wb_we,
   output lsu_pkg::addr_t           o_wb_adr,
   output lsu_pkg::data_t           o_wb_dat,
   output logic [`LSU_DATA_W/8-1:0] o_wb_sel,
   input  lsu_pkg::data_t           i_wb_dat,
   input  logic                     i_wb_ack,

   output logic                     o_done_valid,
   output lsu_pkg::cmt_id_t         o_done_cmt_id,
   output lsu_pkg::grp_id_t         o_done_grp_id,
   output logic                     o_done_is_store,
   output lsu_pkg::rd_t             o_done_rd,
   output lsu_pkg::data_t           o_done_data
);
   import lsu_pkg::*;

   logic        w_ldq_valid;
   cmt_id_t     w_ldq_cmt_id;
   grp_id_t     w_ldq_grp_id;
   addr_t       w_ldq_addr;
   size_t       w_ldq_size;
   op_payload_u w_ldq_payload;
   logic        w_ldq_pop;

   logic        w_stq_valid;
   cmt_id_t     w_stq_cmt_id;
   grp_id_t     w_stq_grp_id;
   addr_t       w_stq_addr;
   size_t       w_stq_size;
   op_payload_u w_stq_payload;
   logic        w_stq_pop;

   // ====================
   // Replay queues
   // ====================

   // Load size rides in the payload's load view
   lsu_replay_queue #(.DEPTH(`LSU_LDQ_DEPTH)) u_ldq (
      .i_clk          (i_clk),
      .i_reset        (i_reset),
      .i_disp_valid   (i_ld_valid),
      .o_disp_ready   (o_ld_ready),
      .i_disp_cmt_id  (i_ld_cmt_id),
      .i_disp_grp_id  (i_ld_grp_id),
      .i_disp_addr    (i_ld_addr),
      .i_disp_size    (i_ld_payload.ld.size),
      .i_disp_payload (i_ld_payload),
      .o_head_valid   (w_ldq_valid),
      .o_head_cmt_id  (w_ldq_cmt_id),
      .o_head_grp_id  (w_ldq_grp_id),
      .o_head_addr    (w_ldq_addr),
      .o_head_size    (w_ldq_size),
      .o_head_payload (w_ldq_payload),
      .i_pop          (w_ldq_pop)
   );

   lsu_replay_queue #(.DEPTH(`LSU_STQ_DEPTH)) u_stq (
      .i_clk          (i_clk),
      .i_reset        (i_reset),
      .i_disp_valid   (i_st_valid),
      .o_disp_ready   (o_st_ready),
      .i_disp_cmt_id  (i_st_cmt_id),
      .i_disp_grp_id  (i_st_grp_id),
      .i_disp_addr    (i_st_addr),
      .i_disp_size    (i_st_size),
      .i_disp_payload (i_st_payload),
      .o_head_valid   (w_stq_valid),
      .o_head_cmt_id  (w_stq_cmt_id),
      .o_head_grp_id  (w_stq_grp_id),
      .o_head_addr    (w_stq_addr),
      .o_head_size    (w_stq_size),
      .o_head_payload (w_stq_payload),
      .i_pop          (w_stq_pop)
   );

   lsu u_lsu (
      .i_clk           (i_clk),
      .i_reset         (i_reset),
      .i_ldq_valid     (w_ldq_valid),
      .i_ldq_cmt_id    (w_ldq_cmt_id),
      .i_ldq_grp_id    (w_ldq_grp_id),
      .i_ldq_addr      (w_ldq_addr),
      .i_ldq_size      (w_ldq_size),
      .i_ldq_payload   (w_ldq_payload),
      .o_ldq_pop       (w_ldq_pop),
      .i_stq_valid     (w_stq_valid),
      .i_stq_cmt_id    (w_stq_cmt_id),
      .i_stq_grp_id    (w_stq_grp_id),
      .i_stq_addr      (w_stq_addr),
      .i_stq_size      (w_stq_size),
      .i_stq_payload   (w_stq_payload),
      .o_stq_pop       (w_stq_pop),
      .o_wb_cyc        (o_wb_cyc),
      .o_wb_stb        (o_wb_stb),
      .o_wb_we         (o_wb_we),
      .o_wb_adr        (o_wb_adr),
      .o_wb_dat        (o_wb_dat),
      .o_wb_sel        (o_wb_sel),
      .i_wb_dat        (i_wb_dat),
      .i_wb_ack        (i_wb_ack),
      .o_done_valid    (o_done_valid),
      .o_done_cmt_id   (o_done_cmt_id),
      .o_done_grp_id   (o_done_grp_id),
      .o_done_is_store (o_done_is_store),
      .o_done_rd       (o_done_rd),
      .o_done_data     (o_done_data)
   );

endmodule

//--- hdl/lsu.sv
`include "lsu_cfg.svh"

module lsu (
   input  logic                     i_clk,
   input  logic                     i_reset,

   // Load queue head
   input  logic                     i_ldq_valid,
   input  lsu_pkg::cmt_id_t         i_ldq_cmt_id,
   input  lsu_pkg::grp_id_t         i_ldq_grp_id,
   input  lsu_pkg::addr_t           i_ldq_addr,
   input  lsu_pkg::size_t           i_ldq_size,
   input  lsu_pkg::op_payload_u     i_ldq_payload,
   output logic                     o_ldq_pop,

   // Store queue head
   input  logic                     i_stq_valid,
   input  lsu_pkg::cmt_id_t         i_stq_cmt_id,
   input  lsu_pkg::grp_id_t         i_stq_grp_id,
   input  lsu_pkg::addr_t           i_stq_addr,
   input  lsu_pkg::size_t           i_stq_size,
   input  lsu_pkg::op_payload_u     i_stq_payload,
   output logic                     o_stq_pop,

   output logic                     o_wb_cyc,
   output logic                     o_wb_stb,
   output logic                     o_wb_we,
   output lsu_pkg::addr_t           o_wb_adr,
   output lsu_pkg::data_t           o_wb_dat,
   output logic [`LSU_DATA_W/8-1:0] o_wb_sel,
   input  lsu_pkg::data_t           i_wb_dat,
   input  logic                     i_wb_ack,

   output logic                     o_done_valid,
   output lsu_pkg::cmt_id_t         o_done_cmt_id,
   output lsu_pkg::grp_id_t         o_done_grp_id,
   output logic                     o_done_is_store,
   output lsu_pkg::rd_t             o_done_rd,
   output lsu_pkg::data_t           o_done_data
);
   import lsu_pkg::*;

   logic        w_ld_is_older_than_st;
   logic        w_ld_selected;
   logic        w_ex0_ready;
   cmt_id_t     w_ex0_cmt_id;
   grp_id_t     w_ex0_grp_id;
   addr_t       w_ex0_addr;
   size_t       w_ex0_size;
   op_payload_u w_ex0_payload;

   lsu_age_check u_pipe_age (
      .i_cmt_id0        (i_ldq_cmt_id),
      .i_grp_id0        (i_ldq_grp_id),
      .i_cmt_id1        (i_stq_cmt_id),
      .i_grp_id1        (i_stq_grp_id),
      .o_0_older_than_1 (w_ld_is_older_than_st)
   );

   // Load wins when alone or older
   assign w_ld_selected = i_ldq_valid & (~i_stq_valid | w_ld_is_older_than_st);

   assign w_ex0_cmt_id  = w_ld_selected ? i_ldq_cmt_id  : i_stq_cmt_id;
   assign w_ex0_grp_id  = w_ld_selected ? i_ldq_grp_id  : i_stq_grp_id;
   assign w_ex0_addr    = w_ld_selected ? i_ldq_addr    : i_stq_addr;
   assign w_ex0_size    = w_ld_selected ? i_ldq_size    : i_stq_size;
   assign w_ex0_payload = w_ld_selected ? i_ldq_payload : i_stq_payload;

   // Only the winner leaves its queue, and only on accept
   assign o_ldq_pop = w_ld_selected & w_ex0_ready;
   assign o_stq_pop = i_stq_valid & ~w_ld_selected & w_ex0_ready;

   // ====================
   // Memory pipe
   // ====================
   lsu_pipe u_lsu_pipe (
      .i_clk           (i_clk),
      .i_reset         (i_reset),
      .i_ex0_valid     (i_ldq_valid | i_stq_valid),
      .o_ex0_ready     (w_ex0_ready),
      .i_ex0_is_store  (~w_ld_selected),
      .i_ex0_cmt_id    (w_ex0_cmt_id),
      .i_ex0_grp_id    (w_ex0_grp_id),
      .i_ex0_addr      (w_ex0_addr),
      .i_ex0_size      (w_ex0_size),
      .i_ex0_payload   (w_ex0_payload),
      .o_wb_cyc        (o_wb_cyc),
      .o_wb_stb        (o_wb_stb),
      .o_wb_we         (o_wb_we),
      .o_wb_adr        (o_wb_adr),
      .o_wb_dat        (o_wb_dat),
      .o_wb_sel        (o_wb_sel),
      .i_wb_dat        (i_wb_dat),
      .i_wb_ack        (i_wb_ack),
      .o_done_valid    (o_done_valid),
      .o_done_cmt_id   (o_done_cmt_id),
      .o_done_grp_id   (o_done_grp_id),
      .o_done_is_store (o_done_is_store),
      .o_done_rd       (o_done_rd),
      .o_done_data     (o_done_data)
   );

endmodule

//--- hdl/lsu_pipe.sv
`include "lsu_cfg.svh"

module lsu_pipe (
   input  logic                     i_clk,
   input  logic                     i_reset,

   input  logic                     i_ex0_valid,
   output logic                     o_ex0_ready,
   input  logic                     i_ex0_is_store,
   input  lsu_pkg::cmt_id_t         i_ex0_cmt_id,
   input  lsu_pkg::grp_id_t         i_ex0_grp_id,
   input  lsu_pkg::addr_t           i_ex0_addr,
   input  lsu_pkg::size_t           i_ex0_size,
   input  lsu_pkg::op_payload_u     i_ex0_payload,

   output logic                     o_wb_cyc,
   output logic                     o_wb_stb,
   output logic                     o_wb_we,
   output lsu_pkg::addr_t           o_wb_adr,
   output lsu_pkg::data_t           o_wb_dat,
   output logic [`LSU_DATA_W/8-1:0] o_wb_sel,
   input  lsu_pkg::data_t           i_wb_dat,
   input  logic                     i_wb_ack,

   output logic                     o_done_valid,
   output lsu_pkg::cmt_id_t         o_done_cmt_id,
   output lsu_pkg::grp_id_t         o_done_grp_id,
   output logic                     o_done_is_store,
   output lsu_pkg::rd_t             o_done_rd,
   output lsu_pkg::data_t           o_done_data
);
   import lsu_pkg::*;

   localparam int SEL_W  = `LSU_DATA_W / 8;
   localparam int LANE_W = $clog2(SEL_W);

   localparam logic [1:0] ST_IDLE = 2'd0;
   localparam logic [1:0] ST_BUS  = 2'd1;
   localparam logic [1:0] ST_DONE = 2'd2;

   logic [1:0]       r_state;
   logic             r_is_store;
   cmt_id_t          r_cmt_id;
   grp_id_t          r_grp_id;
   addr_t            r_addr;
   size_t            r_size;
   op_payload_u      r_payload;
   data_t            r_rdata;

   logic             w_accept;
   logic             w_cyc;
   logic [LANE_W-1:0] w_lane;
   logic [SEL_W-1:0] w_sel;
   logic             w_ext;
   data_t            w_ld_shift;
   data_t            w_ld_data;

   assign o_ex0_ready = r_state == ST_IDLE;
   assign w_accept    = i_ex0_valid & o_ex0_ready;
   assign w_cyc       = r_state == ST_BUS;

   // ====================
   // State machine
   // ====================
   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         r_state <= ST_IDLE;
      end else begin
         case (r_state)
            ST_IDLE: if (i_ex0_valid) r_state <= ST_BUS;
            ST_BUS:  if (i_wb_ack) r_state <= ST_DONE;
            default: r_state <= ST_IDLE;
         endcase
      end
   end

   // Operation held steady for the whole bus cycle
   always_ff @(posedge i_clk) begin
      if (w_accept) begin
         r_is_store <= i_ex0_is_store;
         r_cmt_id   <= i_ex0_cmt_id;
         r_grp_id   <= i_ex0_grp_id;
         r_addr     <= i_ex0_addr;
         r_size     <= i_ex0_size;
         r_payload  <= i_ex0_payload;
      end
      if (w_cyc && i_wb_ack) begin
         r_rdata <= i_wb_dat;
      end
   end

   // ====================
   // Byte lanes
   // ====================
   assign w_lane = r_addr[LANE_W-1:0];

   always_comb begin
      case (r_size)
         SZ_BYTE: w_sel = SEL_W'(1) << w_lane;
         SZ_HALF: w_sel = SEL_W'(3) << {w_lane[LANE_W-1], 1'b0};
         default: w_sel = '1;
      endcase
   end

   assign o_wb_cyc = w_cyc;
   assign o_wb_stb = w_cyc;
   assign o_wb_we  = w_cyc & r_is_store;
   assign o_wb_adr = {r_addr[`LSU_ADDR_W-1:LANE_W], {LANE_W{1'b0}}};
   assign o_wb_sel = w_sel;
   assign o_wb_dat = r_payload.st_data << {w_lane, 3'b000};

   // Load return, shifted down then extended
   assign w_ld_shift = r_rdata >> {w_lane, 3'b000};
   assign w_ext      = ~r_payload.ld.is_unsigned;

   always_comb begin
      case (r_size)
         SZ_BYTE: w_ld_data = {{(`LSU_DATA_W-8){w_ext & w_ld_shift[7]}}, w_ld_shift[7:0]};
         SZ_HALF: w_ld_data = {{(`LSU_DATA_W-16){w_ext & w_ld_shift[15]}}, w_ld_shift[15:0]};
         default: w_ld_data = w_ld_shift;
      endcase
   end

   assign o_done_valid    = r_state == ST_DONE;
   assign o_done_cmt_id   = r_cmt_id;
   assign o_done_grp_id   = r_grp_id;
   assign o_done_is_store = r_is_store;
   assign o_done_rd       = r_is_store ? '0 : r_payload.ld.rd;
   assign o_done_data     = r_is_store ? '0 : w_ld_data;

endmodule

//--- hdl/lsu_replay_queue.sv
module lsu_replay_queue #(
   parameter int DEPTH = 4
) (
   input  logic                 i_clk,
   input  logic                 i_reset,

   input  logic                 i_disp_valid,
   output logic                 o_disp_ready,
   input  lsu_pkg::cmt_id_t     i_disp_cmt_id,
   input  lsu_pkg::grp_id_t     i_disp_grp_id,
   input  lsu_pkg::addr_t       i_disp_addr,
   input  lsu_pkg::size_t       i_disp_size,
   input  lsu_pkg::op_payload_u i_disp_payload,

   output logic                 o_head_valid,
   output lsu_pkg::cmt_id_t     o_head_cmt_id,
   output lsu_pkg::grp_id_t     o_head_grp_id,
   output lsu_pkg::addr_t       o_head_addr,
   output lsu_pkg::size_t       o_head_size,
   output lsu_pkg::op_payload_u o_head_payload,
   input  logic                 i_pop
);
   import lsu_pkg::*;

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);

   // Entry storage
   cmt_id_t     r_cmt_id  [DEPTH];
   grp_id_t     r_grp_id  [DEPTH];
   addr_t       r_addr    [DEPTH];
   size_t       r_size    [DEPTH];
   op_payload_u r_payload [DEPTH];

   logic [PTR_W-1:0] r_wr_ptr;
   logic [PTR_W-1:0] r_rd_ptr;
   logic [CNT_W-1:0] r_count;
   logic             w_push;
   logic             w_pop;

   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
      next_ptr = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
   endfunction

   assign o_disp_ready = r_count != CNT_W'(DEPTH);
   assign o_head_valid = r_count != '0;

   assign w_push = i_disp_valid & o_disp_ready;
   assign w_pop  = i_pop & o_head_valid;

   // ====================
   // Pointers and count
   // ====================
   always_ff @(posedge i_clk) begin
      if (i_reset) begin
         r_wr_ptr <= '0;
         r_rd_ptr <= '0;
         r_count  <= '0;
      end else begin
         if (w_push) begin
            r_wr_ptr <= next_ptr(r_wr_ptr);
         end
         if (w_pop) begin
            r_rd_ptr <= next_ptr(r_rd_ptr);
         end
         case ({w_push, w_pop})
            2'b10:   r_count <= r_count + 1'b1;
            2'b01:   r_count <= r_count - 1'b1;
            default: r_count <= r_count;
         endcase
      end
   end

   always_ff @(posedge i_clk) begin
      if (w_push) begin
         r_cmt_id[r_wr_ptr]  <= i_disp_cmt_id;
         r_grp_id[r_wr_ptr]  <= i_disp_grp_id;
         r_addr[r_wr_ptr]    <= i_disp_addr;
         r_size[r_wr_ptr]    <= i_disp_size;
         r_payload[r_wr_ptr] <= i_disp_payload;
      end
   end

   // Oldest entry waits at the head until popped
   assign o_head_cmt_id  = r_cmt_id[r_rd_ptr];
   assign o_head_grp_id  = r_grp_id[r_rd_ptr];
   assign o_head_addr    = r_addr[r_rd_ptr];
   assign o_head_size    = r_size[r_rd_ptr];
   assign o_head_payload = r_payload[r_rd_ptr];

endmodule

//--- hdl/lsu_age_check.sv
module lsu_age_check (
   input  lsu_pkg::cmt_id_t i_cmt_id0,
   input  lsu_pkg::grp_id_t i_grp_id0,
   input  lsu_pkg::cmt_id_t i_cmt_id1,
   input  lsu_pkg::grp_id_t i_grp_id1,
   output logic             o_0_older_than_1
);
   import lsu_pkg::*;

   // Top bit of the commit id is the wrap bit
   localparam int IDX_W = $bits(cmt_id_t) - 1;

   logic w_wrap_same;
   logic w_id_older;
   logic w_id_equal;

   assign w_wrap_same = i_cmt_id0[IDX_W] == i_cmt_id1[IDX_W];

   // Index order flips once one side has wrapped
   assign w_id_older = w_wrap_same ?
                       (i_cmt_id0[IDX_W-1:0] < i_cmt_id1[IDX_W-1:0]) :
                       (i_cmt_id0[IDX_W-1:0] > i_cmt_id1[IDX_W-1:0]);

   assign w_id_equal = i_cmt_id0 == i_cmt_id1;

   // Same commit, lower one-hot slot goes first
   assign o_0_older_than_1 = w_id_older | (w_id_equal & (i_grp_id0 < i_grp_id1));

endmodule

//--- hdl/lsu_pkg.sv
`include "lsu_cfg.svh"

package lsu_pkg;

   typedef logic [`LSU_CMT_ID_W-1:0] cmt_id_t;
   typedef logic [`LSU_GRP_W-1:0]    grp_id_t;
   typedef logic [`LSU_ADDR_W-1:0]   addr_t;
   typedef logic [`LSU_DATA_W-1:0]   data_t;

   // Destination register tag of a load
   typedef logic [4:0] rd_t;

   // Access size
   typedef enum logic [1:0] {
      SZ_BYTE = 2'd0,
      SZ_HALF = 2'd1,
      SZ_WORD = 2'd2
   } size_t;

   // Load view of the payload word, rd in the low bits
   typedef struct packed {
      logic [23:0] pad;
      logic        is_unsigned;
      size_t       size;
      rd_t         rd;
   } ld_view_t;

   // One payload word, decoded by operation kind
   typedef union packed {
      ld_view_t ld;
      data_t    st_data;
   } op_payload_u;

endpackage

//--- include/lsu_cfg.svh
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// Commit id, top bit is the wrap bit
`define LSU_CMT_ID_W 4

// One-hot group slot within a commit
`define LSU_GRP_W 2

// Byte address and data word
`define LSU_ADDR_W 12
`define LSU_DATA_W 32

// Replay queue depths
`define LSU_LDQ_DEPTH 4
`define LSU_STQ_DEPTH 4

`endif
